// ==== vlog.f ====
design/ocpPkg.sv
design/ocpRequestDecode.sv
design/ocpBurstSequencer.sv
design/ocpResponseCapture.sv
design/ocpMaster.sv
dv/ocpMasterTb.sv

// ==== Makefile ====
# Verilator build and run of the OCP master testbench
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= ocpMasterTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIMFLAGS  ?=

.PHONY: sim clean

# Build, then run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/ocpMasterTb.sv ====
//////////////////////////////////////////////////////////////////////
// OCP master testbench with clock, reset, bridge and slave stimulus
// Expected beat queue, response model, assertions and watchdog
//////////////////////////////////////////////////////////////////////

module ocpMasterTb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod   = 100;
  localparam int DriveDelay  = 10;
  localparam int ResetCycles = 4;

  // Burst lengths of the directed tests in beats
  localparam int LenWrIncr = 5;
  localparam int LenRdStrm = 4;
  localparam int LenZero   = 1;
  localparam int LenWrap   = 3;
  localparam int LenFreeze = 12;
  localparam int LenBusy   = 6;
  localparam int LenPrio   = 3;
  localparam int LenLong   = 40;
  localparam int TotalBeats = LenWrIncr + LenRdStrm + LenZero + LenWrap + LenFreeze +
                              LenBusy + LenPrio + LenLong;
  // About two cycles per beat with random accept
  // Margin covers the response phase
  localparam int WatchdogCycles = TotalBeats * 20 + 300;

  logic                             Clk;
  logic                             reset;
  logic                             enable;
  logic [ocpPkg::AddrWidth-1:0]     address;
  logic [ocpPkg::BurstLenWidth-1:0] burstLength;
  logic [2:0]                       burstSeq;
  logic [ocpPkg::DataWidth-1:0]     writeData;
  logic                             readRequest;
  logic                             writeRequest;
  logic                             busy;
  ocpPkg::readResultS               readResult;
  ocpPkg::ocpReqS                   ocpReq;
  logic                             MRespAccept;
  logic                             SCmdAccept = 1'b0;
  ocpPkg::respE                     SResp;
  logic [ocpPkg::DataWidth-1:0]     SData;

  // Slave accept randomization
  integer      seed = 32'h342;
  logic [31:0] acceptRnd;

  // Beats still owed by the DUT
  // Front entry is the beat on the bus
  ocpPkg::ocpReqS expBeats[$];

  // Inputs seen at the previous edge
  logic                         prevReset = 1'b1;
  logic                         prevEnable;
  ocpPkg::respE                 prevResp;
  logic [ocpPkg::DataWidth-1:0] prevData;
  ocpPkg::readResultS           prevResult;

  ocpMaster ocpMaster_inst (
    .Clk          (Clk),
    .reset        (reset),
    .enable       (enable),
    .address      (address),
    .burstLength  (burstLength),
    .burstSeq     (burstSeq),
    .writeData    (writeData),
    .readRequest  (readRequest),
    .writeRequest (writeRequest),
    .busy         (busy),
    .readResult   (readResult),
    .ocpReq       (ocpReq),
    .MRespAccept  (MRespAccept),
    .SCmdAccept   (SCmdAccept),
    .SResp        (SResp),
    .SData        (SData)
  );

  initial begin
    Clk = 1'b0;
    forever begin
      #(ClkPeriod / 2);
      Clk = ~Clk;
    end
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic checkField(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want)
      else abortRun($sformatf("ERR %s expected 0x%0h got 0x%0h", name, want, got));
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge Clk);
    #DriveDelay;
  endtask

  // Expected beats from the burst rules of the bridge request
  task automatic queueBeats(input ocpPkg::cmdE cmd, input logic [ocpPkg::AddrWidth-1:0] addr,
                            input logic [ocpPkg::BurstLenWidth-1:0] len,
                            input logic [2:0] seq, input logic [ocpPkg::DataWidth-1:0] data);
    ocpPkg::ocpReqS   beat;
    ocpPkg::burstSeqE effSeq;
    int               n;
    n = int'(len);
    // Zero length still moves one beat
    if (n == 0) begin
      n = 1;
    end
    // Anything but STRM steps like INCR
    effSeq = (seq == ocpPkg::STRM) ? ocpPkg::STRM : ocpPkg::INCR;
    beat = '0;
    beat.MCmd         = cmd;
    beat.MAddr        = addr;
    beat.MData        = data;
    beat.MBurstLength = ocpPkg::BurstLenWidth'(n);
    beat.MBurstSeq    = effSeq;
    for (int i = 0; i < n; i++) begin
      beat.MReqLast = (i == n - 1);
      expBeats.push_back(beat);
      if (effSeq == ocpPkg::INCR) begin
        beat.MAddr = beat.MAddr + ocpPkg::AddrStep;
      end
    end
  endtask

  // One-cycle request pulse on the bridge
  task automatic startBurst(input logic rd, input logic wr,
                            input logic [ocpPkg::AddrWidth-1:0] addr,
                            input logic [ocpPkg::BurstLenWidth-1:0] len,
                            input logic [2:0] seq, input logic [ocpPkg::DataWidth-1:0] data);
    @(posedge Clk);
    #DriveDelay;
    address      = addr;
    burstLength  = len;
    burstSeq     = seq;
    writeData    = data;
    readRequest  = rd;
    writeRequest = wr;
    // Read wins a tie
    queueBeats(rd ? ocpPkg::RD : ocpPkg::WR, addr, len, seq, data);
    @(posedge Clk);
    #DriveDelay;
    readRequest  = 1'b0;
    writeRequest = 1'b0;
  endtask

  // Burst must be fully retired once busy drops
  task automatic finishBurst();
    wait (busy);
    wait (!busy);
    #DriveDelay;
    checkField("expBeats.size", 64'(expBeats.size()), 64'd0);
    checkField("MCmd", 64'(ocpReq.MCmd), 64'(ocpPkg::IDLE));
  endtask

  task automatic driveResponse(input ocpPkg::respE code, input logic [ocpPkg::DataWidth-1:0] data);
    @(posedge Clk);
    #DriveDelay;
    SResp = code;
    SData = data;
  endtask

  task automatic checkBeat(input ocpPkg::ocpReqS want);
    checkField("MCmd", 64'(ocpReq.MCmd), 64'(want.MCmd));
    checkField("MAddr", ocpReq.MAddr, want.MAddr);
    checkField("MBurstLength", 64'(ocpReq.MBurstLength), 64'(want.MBurstLength));
    checkField("MBurstSeq", 64'(ocpReq.MBurstSeq), 64'(want.MBurstSeq));
    checkField("MReqLast", 64'(ocpReq.MReqLast), 64'(want.MReqLast));
    if (want.MCmd == ocpPkg::WR) begin
      checkField("MData", 64'(ocpReq.MData), 64'(want.MData));
    end
  endtask

  always @(posedge Clk) begin
    #DriveDelay;
    acceptRnd  = $random(seed);
    SCmdAccept = acceptRnd[0];
  end

  // Beat monitor against the expected queue
  always @(posedge Clk) begin
    if (!reset) begin
      if (ocpReq.MCmd == ocpPkg::IDLE) begin
        checkField("MReqLast", 64'(ocpReq.MReqLast), 64'd0);
      end else begin
        assert (expBeats.size() != 0)
          else abortRun("Command phase on the bus with no burst outstanding");
        checkBeat(expBeats[0]);
        // Retired when the slave takes it
        if (enable && SCmdAccept) begin
          expBeats.delete(0);
        end
      end
    end
  end

  // Response model one cycle behind SResp
  always @(posedge Clk) begin
    if (!reset && prevReset) begin
      checkField("readResult.valid", 64'(readResult.valid), 64'd0);
      checkField("readResult.fail", 64'(readResult.fail), 64'd0);
      checkField("readResult.err", 64'(readResult.err), 64'd0);
    end else if (!reset && prevEnable) begin
      checkField("readResult.valid", 64'(readResult.valid),
                 64'(prevResp == ocpPkg::DVA || prevResp == ocpPkg::FAIL));
      checkField("readResult.fail", 64'(readResult.fail), 64'(prevResp == ocpPkg::FAIL));
      checkField("readResult.err", 64'(readResult.err), 64'(prevResp == ocpPkg::ERR));
      if (prevResp == ocpPkg::DVA || prevResp == ocpPkg::FAIL) begin
        checkField("readResult.data", 64'(readResult.data), 64'(prevData));
      end
    end else if (!reset) begin
      // Nothing may move while disabled
      checkField("readResult", 64'(readResult), 64'(prevResult));
    end
    prevReset  <= reset;
    prevEnable <= enable;
    prevResp   <= SResp;
    prevData   <= SData;
    prevResult <= readResult;
  end

  // Request group frozen under back-pressure
  holdUnderBackPressure : assert property (
    @(posedge Clk) disable iff (reset)
    (ocpReq.MCmd != ocpPkg::IDLE && !SCmdAccept) |=> $stable(ocpReq)
  ) else abortRun("ocpReq changed while SCmdAccept was low");

  freezeWhenDisabled : assert property (
    @(posedge Clk) disable iff (reset)
    !enable |=> ($stable(ocpReq) && $stable(busy))
  ) else abortRun("ocpReq or busy changed while enable was low");

  initial begin
    repeat (WatchdogCycles) @(posedge Clk);
    abortRun($sformatf("Watchdog expired after %0d cycles, the DUT stopped making progress",
                       WatchdogCycles));
  end

  initial begin
    reset        = 1'b1;
    enable       = 1'b1;
    address      = '0;
    burstLength  = '0;
    burstSeq     = ocpPkg::INCR;
    writeData    = '0;
    readRequest  = 1'b0;
    writeRequest = 1'b0;
    SResp        = ocpPkg::NULL;
    SData        = '0;
    repeat (ResetCycles) @(posedge Clk);
    #DriveDelay;
    reset = 1'b0;

    // Reset values
    checkField("MCmd", 64'(ocpReq.MCmd), 64'(ocpPkg::IDLE));
    checkField("MReqLast", 64'(ocpReq.MReqLast), 64'd0);
    checkField("busy", 64'(busy), 64'd0);
    checkField("MRespAccept", 64'(MRespAccept), 64'd1);
    checkField("readResult.valid", 64'(readResult.valid), 64'd0);
    checkField("readResult.fail", 64'(readResult.fail), 64'd0);
    checkField("readResult.err", 64'(readResult.err), 64'd0);

    // INCR write and STRM read followed by zero length and WRAP bursts
    startBurst(1'b0, 1'b1, 64'h0000_0040_0000_0ff8, 10'(LenWrIncr), ocpPkg::INCR, 8'ha5);
    finishBurst();
    startBurst(1'b1, 1'b0, 64'h0000_0000_dead_0100, 10'(LenRdStrm), ocpPkg::STRM, 8'h00);
    finishBurst();
    startBurst(1'b1, 1'b0, 64'h0000_0000_0000_2000, 10'd0, ocpPkg::INCR, 8'h00);
    finishBurst();
    startBurst(1'b0, 1'b1, 64'h1234_5678_9abc_def0, 10'(LenWrap), ocpPkg::WRAP, 8'h5c);
    finishBurst();

    // Enable dropped in the middle of a burst
    startBurst(1'b0, 1'b1, 64'h0000_0000_0000_8000, 10'(LenFreeze), ocpPkg::INCR, 8'h3c);
    waitCycles(3);
    enable = 1'b0;
    waitCycles(5);
    enable = 1'b1;
    finishBurst();

    // Pulses while busy must not start another burst
    startBurst(1'b0, 1'b1, 64'h0000_0000_0001_0000, 10'(LenBusy), ocpPkg::INCR, 8'h77);
    waitCycles(2);
    checkField("busy", 64'(busy), 64'd1);
    // One pulse per cycle up to the edge that retires the last beat
    while (busy) begin
      readRequest  = 1'b1;
      writeRequest = 1'b1;
      waitCycles(1);
    end
    readRequest  = 1'b0;
    writeRequest = 1'b0;
    checkField("expBeats.size", 64'(expBeats.size()), 64'd0);
    waitCycles(4);
    checkField("MCmd", 64'(ocpReq.MCmd), 64'(ocpPkg::IDLE));

    // Tie goes to read
    startBurst(1'b1, 1'b1, 64'h0000_0000_0000_0400, 10'(LenPrio), ocpPkg::INCR, 8'h99);
    finishBurst();

    // Long BLCK burst wrapping the address space
    startBurst(1'b0, 1'b1, 64'hffff_ffff_ffff_fff0, 10'(LenLong), ocpPkg::BLCK, 8'hc3);
    finishBurst();

    // Each response code once
    driveResponse(ocpPkg::DVA, 8'h5a);
    driveResponse(ocpPkg::FAIL, 8'h81);
    driveResponse(ocpPkg::ERR, 8'h33);
    driveResponse(ocpPkg::NULL, 8'hee);
    driveResponse(ocpPkg::DVA, 8'h19);
    // Capture held while disabled
    // Idle request pulse must be ignored too
    waitCycles(1);
    enable      = 1'b0;
    readRequest = 1'b1;
    SResp       = ocpPkg::FAIL;
    SData       = 8'h44;
    waitCycles(1);
    readRequest = 1'b0;
    waitCycles(2);
    enable = 1'b1;
    SResp  = ocpPkg::NULL;
    for (int i = 0; i < 12; i++) begin
      driveResponse(ocpPkg::respE'(2'(i)), 8'(i * 29 + 3));
    end
    driveResponse(ocpPkg::NULL, 8'h00);
    waitCycles(3);

    if (expBeats.size() != 0) begin
      abortRun($sformatf("ERR expBeats.size expected 0x0 got 0x%0h", expBeats.size()));
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

// ==== design/ocpMaster.sv ====
//////////////////////////////////////////////////////////////////////
// OCP 2.2 master top level
// Bridge request decode, burst sequencer and response capture
//////////////////////////////////////////////////////////////////////

module ocpMaster (
  input  logic                              Clk,
  input  logic                              reset,
  input  logic                              enable,

  // Bridge side
  input  logic [ocpPkg::AddrWidth-1:0]      address,
  input  logic [ocpPkg::BurstLenWidth-1:0]  burstLength,
  input  logic [2:0]                        burstSeq,
  input  logic [ocpPkg::DataWidth-1:0]      writeData,
  input  logic                              readRequest,
  input  logic                              writeRequest,
  output logic                              busy,
  output ocpPkg::readResultS                readResult,

  // OCP side
  output ocpPkg::ocpReqS                    ocpReq,
  output logic                              MRespAccept,
  input  logic                              SCmdAccept,
  input  ocpPkg::respE                      SResp,
  input  logic [ocpPkg::DataWidth-1:0]      SData
);

  // Decode to sequencer
  ocpPkg::burstReqS req;
  logic             reqValid;

  // Responses always accepted
  assign MRespAccept = 1'b1;

  ocpRequestDecode ocpRequestDecode_inst (
    .Clk          (Clk),
    .reset        (reset),
    .enable       (enable),
    .busy         (busy),
    .readRequest  (readRequest),
    .writeRequest (writeRequest),
    .address      (address),
    .burstLength  (burstLength),
    .burstSeq     (burstSeq),
    .writeData    (writeData),
    .req          (req),
    .reqValid     (reqValid)
  );

  ocpBurstSequencer ocpBurstSequencer_inst (
    .Clk        (Clk),
    .reset      (reset),
    .enable     (enable),
    .req        (req),
    .reqValid   (reqValid),
    .SCmdAccept (SCmdAccept),
    .ocpReq     (ocpReq),
    .busy       (busy)
  );

  // Read data path
  ocpResponseCapture ocpResponseCapture_inst (
    .Clk    (Clk),
    .reset  (reset),
    .enable (enable),
    .SResp  (SResp),
    .SData  (SData),
    .result (readResult)
  );

endmodule

// ==== design/ocpResponseCapture.sv ====
//////////////////////////////////////////////////////////////////////
// Slave response capture
// Registers SData and DVA, FAIL and ERR status pulses
//////////////////////////////////////////////////////////////////////

module ocpResponseCapture (
  input  logic                         Clk,
  input  logic                         reset,
  input  logic                         enable,
  input  ocpPkg::respE                 SResp,
  input  logic [ocpPkg::DataWidth-1:0] SData,
  output ocpPkg::readResultS           result
);

  // DVA and FAIL both carry data
  logic dataResp;
  logic failResp;
  logic errResp;

  assign dataResp = (SResp == ocpPkg::DVA) || (SResp == ocpPkg::FAIL);
  assign failResp = (SResp == ocpPkg::FAIL);
  assign errResp  = (SResp == ocpPkg::ERR);

  // Flags pulse one cycle after the response
  always_ff @(posedge Clk) begin
    if (reset) begin
      result.valid <= 1'b0;
      result.fail  <= 1'b0;
      result.err   <= 1'b0;
    end else if (enable) begin
      result.valid <= dataResp;
      result.fail  <= failResp;
      result.err   <= errResp;
      // Last read data kept between responses
      if (dataResp) begin
        result.data <= SData;
      end
    end
  end

endmodule

// ==== design/ocpBurstSequencer.sv ====
//////////////////////////////////////////////////////////////////////
// OCP command phase FSM with beat counter
// Address stepping per burst sequence and MReqLast generation
//////////////////////////////////////////////////////////////////////

module ocpBurstSequencer (
  input  logic             Clk,
  input  logic             reset,
  input  logic             enable,
  input  ocpPkg::burstReqS req,
  input  logic             reqValid,
  input  logic             SCmdAccept,
  output ocpPkg::ocpReqS   ocpReq,
  output logic             busy
);

  localparam logic [ocpPkg::BurstLenWidth-1:0] OneBeat = 1;

  // State doubles as the MCmd value on the bus
  ocpPkg::cmdE                      state;
  logic [ocpPkg::BurstLenWidth-1:0] beatCount;

  // Command payload held for the whole burst
  logic [ocpPkg::AddrWidth-1:0]     addrReg;
  logic [ocpPkg::DataWidth-1:0]     dataReg;
  logic [ocpPkg::BurstLenWidth-1:0] lenReg;
  ocpPkg::burstSeqE                 seqReg;

  logic start;
  logic beatDone;
  logic lastBeat;

  // New burst only from IDLE
  assign start = enable && (state == ocpPkg::IDLE) && reqValid;

  // Beat ends when slave samples SCmdAccept on an active command
  assign beatDone = enable && (state != ocpPkg::IDLE) && SCmdAccept;

  // Final beat of the burst
  assign lastBeat = (state != ocpPkg::IDLE) && (beatCount == lenReg - OneBeat);

  assign busy = (state != ocpPkg::IDLE);

  // Command state
  always_ff @(posedge Clk) begin
    if (reset) begin
      state <= ocpPkg::IDLE;
    end else if (enable) begin
      case (state)
        ocpPkg::IDLE: begin
          if (reqValid) begin
            state <= req.cmd;
          end
        end
        ocpPkg::WR,
        ocpPkg::RD: begin
          // Back to IDLE once the last beat is taken
          if (SCmdAccept && lastBeat) begin
            state <= ocpPkg::IDLE;
          end
        end
        default: begin
          state <= ocpPkg::IDLE;
        end
      endcase
    end
  end

  // Beat counter, cleared at burst start
  always_ff @(posedge Clk) begin
    if (reset) begin
      beatCount <= '0;
    end else if (start) begin
      beatCount <= '0;
    end else if (beatDone && !lastBeat) begin
      beatCount <= beatCount + OneBeat;
    end
  end

  // Payload load and address stepping
  always_ff @(posedge Clk) begin
    if (start) begin
      addrReg <= req.addr;
      lenReg  <= req.burstLen;
      seqReg  <= req.burstSeq;
      // Reads drive zero data
      if (req.cmd == ocpPkg::WR) begin
        dataReg <= req.writeData;
      end else begin
        dataReg <= '0;
      end
    end else if (beatDone && !lastBeat) begin
      // STRM keeps the same address
      if (seqReg == ocpPkg::INCR) begin
        addrReg <= addrReg + ocpPkg::AddrStep;
      end
    end
  end

  // Outputs stay put while SCmdAccept is low
  assign ocpReq = '{
    MCmd:         state,
    MAddr:        addrReg,
    MData:        dataReg,
    MBurstLength: lenReg,
    MBurstSeq:    seqReg,
    MReqLast:     lastBeat
  };

endmodule

// ==== design/ocpRequestDecode.sv ====
//////////////////////////////////////////////////////////////////////
// Bridge request sampler
// Read over write priority, burst length and sequence cleanup
//////////////////////////////////////////////////////////////////////

module ocpRequestDecode (
  input  logic                              Clk,
  input  logic                              reset,
  input  logic                              enable,
  input  logic                              busy,
  input  logic                              readRequest,
  input  logic                              writeRequest,
  input  logic [ocpPkg::AddrWidth-1:0]      address,
  input  logic [ocpPkg::BurstLenWidth-1:0]  burstLength,
  input  logic [2:0]                        burstSeq,
  input  logic [ocpPkg::DataWidth-1:0]      writeData,
  output ocpPkg::burstReqS                  req,
  output logic                              reqValid
);

  // Shortest legal burst
  localparam logic [ocpPkg::BurstLenWidth-1:0] OneBeat = 1;

  logic             accept;
  ocpPkg::burstReqS nextReq;

  // Pulses count only while running and idle
  // Strobe cycle blocked too, busy rises one cycle later
  assign accept = enable && !busy && !reqValid && (readRequest || writeRequest);

  always_comb begin
    nextReq = '0;
    // Read wins when both pulse together
    if (readRequest) begin
      nextReq.cmd = ocpPkg::RD;
    end else begin
      nextReq.cmd = ocpPkg::WR;
    end
    nextReq.addr      = address;
    nextReq.writeData = writeData;
    // Zero length treated as a single beat
    if (burstLength == '0) begin
      nextReq.burstLen = OneBeat;
    end else begin
      nextReq.burstLen = burstLength;
    end
    // Unsupported sequences fall back to incrementing
    if (burstSeq == ocpPkg::STRM) begin
      nextReq.burstSeq = ocpPkg::STRM;
    end else begin
      nextReq.burstSeq = ocpPkg::INCR;
    end
  end

  // One-cycle strobe toward the sequencer
  always_ff @(posedge Clk) begin
    if (reset) begin
      reqValid <= 1'b0;
    end else if (enable) begin
      reqValid <= accept;
    end
  end

  // Request payload, loaded only on accept
  always_ff @(posedge Clk) begin
    if (enable && accept) begin
      req <= nextReq;
    end
  end

endmodule

// ==== design/ocpPkg.sv ====
//////////////////////////////////////////////////////////////////////
// OCP 2.2 profile widths and encodings for the master
// Decoded request, OCP request group and captured response structs
//////////////////////////////////////////////////////////////////////

package ocpPkg;

  // Basic group widths for this profile
  localparam int AddrWidth = 64;
  localparam int DataWidth = 8;

  // Burst group width
  localparam int BurstLenWidth = 10;

  // Byte address advance per beat
  localparam logic [AddrWidth-1:0] AddrStep = DataWidth / 8;

  // MCmd codes
  typedef enum logic [2:0] {
    IDLE = 3'b000,
    WR   = 3'b001,
    RD   = 3'b010,
    RDEX = 3'b011,
    RDL  = 3'b100,
    WRNP = 3'b101,
    WRC  = 3'b110,
    BCST = 3'b111
  } cmdE;

  // SResp codes
  typedef enum logic [1:0] {
    NULL = 2'b00,
    DVA  = 2'b01,
    FAIL = 2'b10,
    ERR  = 2'b11
  } respE;

  // MBurstSeq codes, only INCR and STRM are generated
  typedef enum logic [2:0] {
    INCR  = 3'b000,
    DFLT1 = 3'b001,
    WRAP  = 3'b010,
    DFLT2 = 3'b011,
    XOR   = 3'b100,
    STRM  = 3'b101,
    UNKN  = 3'b110,
    BLCK  = 3'b111
  } burstSeqE;

  // Request as handed from decode to sequencer
  typedef struct packed {
    cmdE                      cmd;
    logic [AddrWidth-1:0]     addr;
    logic [BurstLenWidth-1:0] burstLen;
    burstSeqE                 burstSeq;
    logic [DataWidth-1:0]     writeData;
  } burstReqS;

  // OCP request phase signals driven toward the slave
  typedef struct packed {
    cmdE                      MCmd;
    logic [AddrWidth-1:0]     MAddr;
    logic [DataWidth-1:0]     MData;
    logic [BurstLenWidth-1:0] MBurstLength;
    burstSeqE                 MBurstSeq;
    logic                     MReqLast;
  } ocpReqS;

  // Registered slave response
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 valid;
    logic                 fail;
    logic                 err;
  } readResultS;

endpackage
